// ==== common/mondo_pkg.sv ====
////////////////////
// Mondo field widths, entry count and timebase types
////////////////////

package mondo_pkg;

   ////////////////////
   // Entry tracking
   ////////////////////

   // One entry per CPU ID
   localparam int mto_entries = 32;

   // CPU ID field taken from the mondo header
   localparam int cpu_id_width = 5;

   typedef logic [cpu_id_width-1:0] cpu_id_t;   // Target CPU of a mondo

   // Bit per entry, bit n is CPU n
   typedef logic [mto_entries-1:0] entry_vec_t;

   ////////////////////
   // Timebase
   ////////////////////

   localparam int timebase_width = 32;   // Counter and timeout compare width

   // Free running count, also the programmed wrap value
   typedef logic [timebase_width-1:0] timebase_t;

endpackage

// ==== common/mto_csr_pkg.sv ====
////////////////////
// APB register map of the mondo timeout block
////////////////////

package mto_csr_pkg;

   ////////////////////
   // Bus widths
   ////////////////////

   localparam int apb_addr_width = 8;   // Byte offset into the block

   typedef logic [apb_addr_width-1:0] apb_addr_t;
   typedef logic [31:0] apb_data_t;     // Full word registers only

   ////////////////////
   // Register offsets
   ////////////////////

   localparam apb_addr_t csr_timeval_addr = 8'h00;   // RW, timebase wrap value
   localparam apb_addr_t csr_ctrl_addr    = 8'h04;   // WO, reads back 0
   localparam apb_addr_t csr_status_addr  = 8'h08;   // RO, sticky error bits

   ////////////////////
   // Fields and resets
   ////////////////////

   // Ctrl write with this bit set restarts the timebase
   localparam int ctrl_restart_bit = 0;

   // Timeout value out of reset
   localparam logic [31:0] timeval_reset = 32'h0000_00ff;

endpackage

// ==== common/mto_lane_if.sv ====
////////////////////
// Per-entry link between dispatch, slice and CSR block
////////////////////

`timescale 1ns/100ps

interface mto_lane_if;

   logic set;    // Header seen for this CPU
   logic clr;    // Ack issued for this CPU
   logic wrap;   // Shared timebase wrap
   logic err;    // Sticky timeout error

   // Decode side
   modport dispatch (
      output set,
      output clr,
      output wrap
   );

   // Entry state holder
   modport slice (
      input  set,
      input  clr,
      input  wrap,
      output err
   );

   // Error gathering for status and intr output
   modport collect (
      input err
   );

endinterface

// ==== mto/mto_dispatch.sv ====
////////////////////
// Mondo timeout dispatch
// Timebase counter plus header and ack decode into per-entry set and clear
////////////////////

`timescale 1ns/100ps

module mto_dispatch
   import mondo_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   // Mondo header arrival
   input  logic                mondo_hdr_push,
   input  cpu_id_t             mondo_hdr_cpu_id,
   // Acknowledge issue
   input  logic                mondo_ack,
   input  cpu_id_t             mondo_ack_cpu_id,
   // From CSR block
   input  timebase_t           timeval,
   input  logic                restart,
   // One lane per entry
   mto_lane_if.dispatch        lanes [mto_entries]
);

   timebase_t tb_cnt;     // Shared timebase
   logic      tb_wrap;    // Count hit the programmed value

   ////////////////////
   // Timebase
   ////////////////////

   // Wrap on the matching cycle, back to 0 on the next
   assign tb_wrap = (tb_cnt == timeval);

   always_ff @(posedge clk) begin
      if (rst) begin
         tb_cnt <= '0;
      end else if (restart || tb_wrap) begin
         tb_cnt <= '0;            // Restart or natural wrap
      end else begin
         tb_cnt <= tb_cnt + 1'b1;
      end
   end

   ////////////////////
   // Lane decode
   ////////////////////

   // One compare per entry for each strobe
   for (genvar i = 0; i < mto_entries; i++) begin : g_lane
      assign lanes[i].set  = mondo_hdr_push && (mondo_hdr_cpu_id == cpu_id_t'(i));
      assign lanes[i].clr  = mondo_ack && (mondo_ack_cpu_id == cpu_id_t'(i));
      assign lanes[i].wrap = tb_wrap;   // Same wrap to every entry
   end

endmodule

// ==== mto/mto_slice.sv ====
////////////////////
// One mondo entry: valid, armed and sticky timeout error
////////////////////

`timescale 1ns/100ps

module mto_slice (
   input  logic      clk,
   input  logic      rst,
   mto_lane_if.slice lane
);

   logic valid;         // Interrupt outstanding
   logic armed;         // First wrap already seen
   logic timeout_err;   // Second wrap seen, held until ack

   // Priority: clear, then set, then wrap
   always_ff @(posedge clk) begin
      if (rst || lane.clr) begin
         valid       <= 1'b0;
         armed       <= 1'b0;
         timeout_err <= 1'b0;   // Ack also drops the error
      end else if (lane.set) begin
         // New header restarts the two-wrap window
         valid <= 1'b1;
         armed <= 1'b0;
      end else if (lane.wrap && valid) begin
         if (!armed) begin
            armed <= 1'b1;        // First wrap
         end else begin
            timeout_err <= 1'b1;  // Second wrap, no ack yet
         end
      end
   end

   // Straight to CSR block, no extra stage
   assign lane.err = timeout_err;

endmodule

// ==== mto/mto_csr.sv ====
////////////////////
// Mondo timeout APB registers
// Timeout value, timebase restart and error status collection
////////////////////

`timescale 1ns/100ps

module mto_csr
   import mondo_pkg::*;
   import mto_csr_pkg::*;
(
   input  logic           clk,
   input  logic           rst,
   // APB slave
   input  logic           psel,
   input  logic           penable,
   input  logic           pwrite,
   input  apb_addr_t      paddr,
   input  apb_data_t      pwdata,
   output apb_data_t      prdata,
   output logic           pready,
   output logic           pslverr,
   // To dispatch
   output timebase_t      timeval,
   output logic           restart,
   // Error bits from every entry
   mto_lane_if.collect    lanes [mto_entries],
   output entry_vec_t     intr_timeout_err
);

   logic       apb_access;    // Second phase of a transfer
   logic       hit_timeval;
   logic       hit_ctrl;
   logic       hit_status;
   logic       addr_mapped;
   logic       wr_timeval;
   logic       wr_ctrl;
   timebase_t  timeval_q;     // Programmed wrap value
   logic       restart_q;     // One cycle restart pulse
   entry_vec_t err_vec;       // Gathered lane errors

   ////////////////////
   // Address decode
   ////////////////////

   assign apb_access  = psel && penable;
   assign hit_timeval = (paddr == csr_timeval_addr);
   assign hit_ctrl    = (paddr == csr_ctrl_addr);
   assign hit_status  = (paddr == csr_status_addr);
   assign addr_mapped = hit_timeval || hit_ctrl || hit_status;

   assign wr_timeval = apb_access && pwrite && hit_timeval;
   assign wr_ctrl    = apb_access && pwrite && hit_ctrl;

   // No wait states
   assign pready = apb_access;

   // Unmapped offset or write to the read-only status word
   assign pslverr = apb_access && (!addr_mapped || (pwrite && hit_status));

   ////////////////////
   // Registers
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         timeval_q <= timeval_reset;
         restart_q <= 1'b0;
      end else begin
         if (wr_timeval) begin
            timeval_q <= timebase_t'(pwdata);
         end
         // Pulse lands one cycle after the ctrl write
         restart_q <= wr_ctrl && pwdata[ctrl_restart_bit];
      end
   end

   assign timeval = timeval_q;
   assign restart = restart_q;

   ////////////////////
   // Error collection
   ////////////////////

   for (genvar i = 0; i < mto_entries; i++) begin : g_err
      assign err_vec[i] = lanes[i].err;
   end

   assign intr_timeout_err = err_vec;   // No added latency

   // Read mux, ctrl and unmapped read as 0
   always_comb begin
      prdata = '0;
      if (hit_timeval) begin
         prdata = apb_data_t'(timeval_q);
      end else if (hit_status) begin
         prdata = apb_data_t'(err_vec);
      end
   end

endmodule

// ==== src/mondo_timeout_top.sv ====
////////////////////
// Mondo interrupt ack timeout monitor, top level
////////////////////

`timescale 1ns/100ps

module mondo_timeout_top
   import mondo_pkg::*;
   import mto_csr_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   // Mondo traffic
   input  logic       mondo_hdr_push,
   input  cpu_id_t    mondo_hdr_cpu_id,
   input  logic       mondo_ack,
   input  cpu_id_t    mondo_ack_cpu_id,
   // APB slave
   input  logic       psel,
   input  logic       penable,
   input  logic       pwrite,
   input  apb_addr_t  paddr,
   input  apb_data_t  pwdata,
   output apb_data_t  prdata,
   output logic       pready,
   output logic       pslverr,
   // Timeout interrupt, one bit per CPU
   output entry_vec_t intr_timeout_err
);

   timebase_t timeval;   // CSR to timebase
   logic      restart;   // CSR restart pulse

   mto_lane_if lanes [mto_entries] ();   // Per-entry links

   // Timebase and decode
   mto_dispatch u_dispatch (
      .clk              (clk),
      .rst              (rst),
      .mondo_hdr_push   (mondo_hdr_push),
      .mondo_hdr_cpu_id (mondo_hdr_cpu_id),
      .mondo_ack        (mondo_ack),
      .mondo_ack_cpu_id (mondo_ack_cpu_id),
      .timeval          (timeval),
      .restart          (restart),
      .lanes            (lanes)
   );

   ////////////////////
   // Entry slices
   ////////////////////

   for (genvar i = 0; i < mto_entries; i++) begin : g_slice
      mto_slice u_slice (
         .clk  (clk),
         .rst  (rst),
         .lane (lanes[i])
      );
   end

   // Register block, drains the lane errors
   mto_csr u_csr (
      .clk              (clk),
      .rst              (rst),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .prdata           (prdata),
      .pready           (pready),
      .pslverr          (pslverr),
      .timeval          (timeval),
      .restart          (restart),
      .lanes            (lanes),
      .intr_timeout_err (intr_timeout_err)
   );

endmodule

// ==== testbench/mto_model.svh ====
////////////////////
// Reference model of the timebase, CSR state and mondo entries
////////////////////

`ifndef MTO_MODEL_SVH
`define MTO_MODEL_SVH

timebase_t  m_cnt;       // Timebase count
timebase_t  m_timeval;   // Programmed wrap value
logic       m_restart;   // Pending restart pulse
entry_vec_t m_valid;
entry_vec_t m_armed;
entry_vec_t m_err;       // Expected intr_timeout_err

// State right after reset
task automatic model_reset();
   m_cnt     = '0;
   m_timeval = timeval_reset;
   m_restart = 1'b0;
   m_valid   = '0;
   m_armed   = '0;
   m_err     = '0;
endtask

// One clock edge, from the inputs seen before it
task automatic model_step(input logic hdr_push, input cpu_id_t hdr_id, input logic ack,
                          input cpu_id_t ack_id, input logic apb_wr, input apb_addr_t addr,
                          input apb_data_t data);
   logic wrap;
   wrap = (m_cnt == m_timeval);
   for (int i = 0; i < mto_entries; i++) begin
      if (ack && (ack_id == cpu_id_t'(i))) begin
         m_valid[i] = 1'b0;   // Ack wins over everything
         m_armed[i] = 1'b0;
         m_err[i]   = 1'b0;
      end else if (hdr_push && (hdr_id == cpu_id_t'(i))) begin
         m_valid[i] = 1'b1;   // Window restarts, err kept
         m_armed[i] = 1'b0;
      end else if (wrap && m_valid[i]) begin
         if (m_armed[i]) m_err[i] = 1'b1;   // Second wrap
         else m_armed[i] = 1'b1;
      end
   end
   if (m_restart || wrap) m_cnt = '0;
   else m_cnt = m_cnt + timebase_t'(1);
   // Register writes land at this edge
   m_restart = apb_wr && (addr == csr_ctrl_addr) && data[ctrl_restart_bit];
   if (apb_wr && (addr == csr_timeval_addr)) m_timeval = timebase_t'(data);
endtask

// Register view seen by an APB read
function automatic apb_data_t model_rdata(input apb_addr_t addr);
   if (addr == csr_timeval_addr) return apb_data_t'(m_timeval);
   if (addr == csr_status_addr) return apb_data_t'(m_err);
   return '0;   // Ctrl and holes
endfunction

`endif

// ==== testbench/mto_tb.sv ====
////////////////////
// Mondo timeout monitor testbench
// Random mondo traffic and APB accesses checked against a model
////////////////////

`timescale 1ns/100ps

module mto_tb
   import mondo_pkg::*;
   import mto_csr_pkg::*;
();

   localparam int num_tests = 6;
   localparam int wd_cycles = num_tests * (int'(timeval_reset) + 2) * 3;   // Run budget

   logic       clk;
   logic       rst;
   logic       mondo_hdr_push;
   cpu_id_t    mondo_hdr_cpu_id;
   logic       mondo_ack;
   cpu_id_t    mondo_ack_cpu_id;
   logic       psel;
   logic       penable;
   logic       pwrite;
   apb_addr_t  paddr;
   apb_data_t  pwdata;
   apb_data_t  prdata;
   logic       pready;
   logic       pslverr;
   entry_vec_t intr_timeout_err;

   integer     seed = 32'hbcb6031a;   // Fixed stimulus seed
   string      test_name;
   apb_data_t  rd;

   `include "mto_model.svh"

   mondo_timeout_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

   ////////////////////
   // Checks
   ////////////////////

   task automatic check_err(input string name, input entry_vec_t exp, input entry_vec_t act);
      if (exp !== act) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_rdata(input string name, input apb_data_t exp, input apb_data_t act);
      if (exp !== act) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_slverr(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("Fail %s: expected %b, actual %b", name, exp, act);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   ////////////////////
   // Drivers
   ////////////////////

   // Model takes the edge, DUT error vector checked just after it
   task automatic next_cycle();
      model_step(mondo_hdr_push, mondo_hdr_cpu_id, mondo_ack, mondo_ack_cpu_id,
                 psel && penable && pwrite, paddr, pwdata);
      @(posedge clk);
      #1;
      check_err(test_name, m_err, intr_timeout_err);
   endtask

   task automatic idle_strobes();
      mondo_hdr_push = 1'b0;
      mondo_ack      = 1'b0;
   endtask

   task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t data,
                           input logic exp_slverr, output apb_data_t rdata);
      psel    = 1'b1;   // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      next_cycle();
      penable = 1'b1;   // Access phase
      #1;
      if (pready !== 1'b1) begin
         $display("pready was not high in the access phase of %s", test_name);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
      check_slverr(test_name, exp_slverr, pslverr);
      if (!wr) check_rdata(test_name, model_rdata(addr), prdata);
      rdata = prdata;
      next_cycle();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_slverr);
      apb_data_t unused;
      apb_xfer(1'b1, addr, data, exp_slverr, unused);
   endtask

   task automatic apb_read(input apb_addr_t addr, input logic exp_slverr, output apb_data_t rdata);
      apb_xfer(1'b0, addr, '0, exp_slverr, rdata);
   endtask

   // New wrap value, then restart so the count is below it
   task automatic set_timeval(input timebase_t v);
      apb_write(csr_timeval_addr, apb_data_t'(v), 1'b0);
      apb_write(csr_ctrl_addr, apb_data_t'(1) << ctrl_restart_bit, 1'b0);
   endtask

   task automatic push_hdr(input cpu_id_t id);
      mondo_hdr_push   = 1'b1;
      mondo_hdr_cpu_id = id;
      next_cycle();
      idle_strobes();
   endtask

   task automatic issue_ack(input cpu_id_t id);
      mondo_ack        = 1'b1;
      mondo_ack_cpu_id = id;
      next_cycle();
      idle_strobes();
   endtask

   task automatic wait_err_bit(input cpu_id_t id, input int max_cycles);
      int n;
      n = 0;
      while (!intr_timeout_err[id] && (n < max_cycles)) begin
         next_cycle();
         n++;
      end
      if (!intr_timeout_err[id]) begin
         $display("Timeout error for CPU %0d never rose in %s", id, test_name);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   // Run budget guard
   initial begin
      repeat (wd_cycles) @(posedge clk);
      $display("Watchdog expired, the tests did not finish in %0d cycles", wd_cycles);
      $display("TESTBENCH FAILED");
      $fatal(1);
   end

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      rst              = 1'b1;
      mondo_hdr_push   = 1'b0;
      mondo_hdr_cpu_id = '0;
      mondo_ack        = 1'b0;
      mondo_ack_cpu_id = '0;
      psel             = 1'b0;
      penable          = 1'b0;
      pwrite           = 1'b0;
      paddr            = '0;
      pwdata           = '0;
      test_name        = "reset values";
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      model_reset();
      check_err(test_name, '0, intr_timeout_err);
      apb_read(csr_status_addr, 1'b0, rd);
      check_rdata(test_name, '0, rd);
      apb_read(csr_timeval_addr, 1'b0, rd);
      check_rdata(test_name, timeval_reset, rd);
      apb_read(csr_ctrl_addr, 1'b0, rd);

      test_name = "single timeout";
      set_timeval(timebase_t'(5));
      push_hdr(cpu_id_t'(3));
      wait_err_bit(cpu_id_t'(3), 3 * (5 + 2));   // Exact cycle fixed by the model

      test_name = "ack before timeout";
      push_hdr(cpu_id_t'(7));
      repeat (3) next_cycle();
      issue_ack(cpu_id_t'(7));
      repeat (3 * (5 + 2)) next_cycle();         // Bit 7 must stay low
      issue_ack(cpu_id_t'(3));                    // Clears the sticky bit
      apb_read(csr_status_addr, 1'b0, rd);

      test_name = "random traffic";
      set_timeval(timebase_t'(9));
      for (int n = 0; n < 600; n++) begin
         mondo_hdr_push   = (({$random(seed)} % 3) == 0);
         mondo_hdr_cpu_id = cpu_id_t'($random(seed));
         mondo_ack        = (({$random(seed)} % 4) == 0);
         mondo_ack_cpu_id = cpu_id_t'($random(seed));
         if (({$random(seed)} % 4) == 0) mondo_ack_cpu_id = mondo_hdr_cpu_id;   // Set and clr clash
         next_cycle();
         if ((n % 50) == 49) begin
            idle_strobes();
            apb_read(csr_status_addr, 1'b0, rd);   // Periodic status poll
         end
      end
      idle_strobes();

      test_name = "timebase restart";
      repeat (4) next_cycle();
      issue_ack(cpu_id_t'(12));                   // Drop any error left by the traffic
      push_hdr(cpu_id_t'(12));
      apb_write(csr_ctrl_addr, apb_data_t'(1) << ctrl_restart_bit, 1'b0);
      apb_write(csr_ctrl_addr, '0, 1'b0);        // No restart bit
      wait_err_bit(cpu_id_t'(12), 3 * (9 + 2));

      test_name = "bad accesses";
      apb_read(csr_timeval_addr, 1'b0, rd);
      apb_write(8'h0c, 32'h0000_1234, 1'b1);
      apb_write(8'hfc, 32'h0000_0001, 1'b1);
      apb_write(csr_status_addr, 32'hffff_ffff, 1'b1);
      apb_read(8'h10, 1'b1, rd);
      check_rdata(test_name, '0, rd);
      apb_read(csr_timeval_addr, 1'b0, rd);
      check_rdata(test_name, apb_data_t'(9), rd);   // Still the value written for traffic
      apb_read(csr_status_addr, 1'b0, rd);
      repeat (3 * (9 + 2)) next_cycle();

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+testbench
common/mondo_pkg.sv
common/mto_csr_pkg.sv
common/mto_lane_if.sv
mto/mto_dispatch.sv
mto/mto_slice.sv
mto/mto_csr.sv
src/mondo_timeout_top.sv
testbench/mto_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the mondo timeout testbench with Verilator and run it.
# The exit status is 0 only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   --top-module mto_tb \
   -f list.f \
   -o mto_sim \
   && ./obj_dir/mto_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed"; exit 1; }
